// File: design/fetch_macros.svh
/*
 * Fetch front end sizing
 * Group width, instruction size, cache and BTB geometry
 */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Instructions per fetch group
`define FETCH_WIDTH 2
// Bytes per instruction word
`define INSN_BYTES 4
// Words per instruction cache line
`define LINE_WORDS 4
// Number of cache lines, direct mapped
`define ICACHE_LINES 8
// Number of BTB entries, direct mapped
`define BTB_ENTRIES 8

// Derived byte counts
`define LINE_BYTES (`LINE_WORDS * `INSN_BYTES)
`define GROUP_BYTES (`FETCH_WIDTH * `INSN_BYTES)

`endif

// File: design/fetchTypes.sv
/*
 * Pipeline types of the fetch front end
 * Lanes, fetch groups, predictions and backend control
 */
`include "fetch_macros.svh"

package fetchTypes;

    // Byte address of an instruction
    typedef logic [31:0] pcT;
    typedef logic [31:0] insnT;

    typedef struct packed {
        logic predTaken;
        pcT   predTarget;
    } branchPredT;

    // One slot of a fetch group
    typedef struct packed {
        logic       valid;
        pcT         pc;
        insnT       insn;
        branchPredT pred;
    } fetchLaneT;

    // Group handed to decode, lane 0 at the lower address
    typedef fetchLaneT [`FETCH_WIDTH-1:0] fetchGroupT;

    // Per-lane cache words and predictions
    typedef insnT [`FETCH_WIDTH-1:0] insnGroupT;
    typedef branchPredT [`FETCH_WIDTH-1:0] predGroupT;

    // Backend flush
    typedef struct packed {
        logic valid;
        pcT   pc;
    } redirectT;

    // Backend BTB install
    typedef struct packed {
        logic valid;
        pcT   branchPc;
        pcT   target;
    } btbUpdateT;

endpackage

// File: design/memTypes.sv
/*
 * Memory side types of the fetch front end
 * Addresses, cache line fields, refill writes and miss FSM states
 */
`include "fetch_macros.svh"

package memTypes;

    typedef logic [31:0] memAddrT;
    typedef logic [31:0] memDataT;
    typedef logic [$clog2(`ICACHE_LINES)-1:0] lineIdxT;
    typedef logic [$clog2(`LINE_WORDS)-1:0] wordOffT;
    // Address bits above index and line offset
    typedef logic [31-$clog2(`LINE_BYTES)-$clog2(`ICACHE_LINES):0] tagT;

    // One refill word for the cache
    typedef struct packed {
        logic    we;
        lineIdxT idx;
        wordOffT word;
        tagT     tag;
        memDataT data;
    } refillReqT;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_LAST
    } refillStateT;

    // Field extraction shared by cache and miss FSM
    function automatic lineIdxT lineIdxOf(memAddrT addr);
        return addr[$clog2(`LINE_BYTES) +: $clog2(`ICACHE_LINES)];
    endfunction

    function automatic tagT tagOf(memAddrT addr);
        return addr[31 -: $bits(tagT)];
    endfunction

    function automatic wordOffT wordOf(memAddrT addr);
        return addr[$clog2(`INSN_BYTES) +: $clog2(`LINE_WORDS)];
    endfunction

    function automatic memAddrT lineBase(memAddrT addr);
        return addr & ~memAddrT'(`LINE_BYTES - 1);
    endfunction

endpackage

// File: design/nextPcStage.sv
/*
 * Next PC stage
 * Holds the fetch address and picks redirect or predicted next group
 */
module nextPcStage (
    input  logic                 clk,
    input  logic                 rst,
    input  fetchTypes::redirectT redirect,
    input  logic                 advance,
    input  fetchTypes::pcT       predPc,
    output fetchTypes::pcT       fetchPc
);

    // Redirect wins over the predicted path
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPc <= '0;
        end else if (redirect.valid) begin
            fetchPc <= redirect.pc;
        end else if (advance) begin
            // Taken target or next aligned group
            fetchPc <= predPc;
        end
    end

endmodule

// File: design/branchTargetBuffer.sv
/*
 * Branch target buffer
 * Direct mapped, full-PC tag, one lookup per lane
 * Entries installed by backend updates
 */
`include "fetch_macros.svh"

module branchTargetBuffer (
    input  logic                  clk,
    input  logic                  rst,
    input  fetchTypes::btbUpdateT btbUpdate,
    input  fetchTypes::pcT        lookupPc,
    output fetchTypes::predGroupT pred
);

    typedef logic [$clog2(`BTB_ENTRIES)-1:0] btbIdxT;

    logic [`BTB_ENTRIES-1:0] entryValid;
    fetchTypes::pcT entryPc [`BTB_ENTRIES];
    fetchTypes::pcT entryTarget [`BTB_ENTRIES];
    fetchTypes::pcT lanePc [`FETCH_WIDTH];
    btbIdxT laneIdx [`FETCH_WIDTH];

    // Word address bits pick the entry
    function automatic btbIdxT btbIndex(fetchTypes::pcT pc);
        return pc[$clog2(`INSN_BYTES) +: $clog2(`BTB_ENTRIES)];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (btbUpdate.valid) begin
            entryValid[btbIndex(btbUpdate.branchPc)] <= 1'b1;
        end
    end

    // Table contents, an update overwrites the old entry
    always_ff @(posedge clk) begin
        if (btbUpdate.valid) begin
            entryPc[btbIndex(btbUpdate.branchPc)] <= btbUpdate.branchPc;
            entryTarget[btbIndex(btbUpdate.branchPc)] <= btbUpdate.target;
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lanePc[i] = lookupPc + fetchTypes::pcT'(i * `INSN_BYTES);
            laneIdx[i] = btbIndex(lanePc[i]);
            // Full tag match means taken
            pred[i].predTaken = entryValid[laneIdx[i]] && (entryPc[laneIdx[i]] == lanePc[i]);
            pred[i].predTarget = entryTarget[laneIdx[i]];
        end
    end

endmodule

// File: design/instCache.sv
/*
 * Instruction cache
 * Direct mapped, combinational group read
 * Filled one word at a time by the miss FSM
 */
`include "fetch_macros.svh"

module instCache (
    input  logic                  clk,
    input  logic                  rst,
    input  fetchTypes::pcT        readPc,
    output logic                  hit,
    output fetchTypes::insnGroupT readWords,
    input  logic                  refillWe,
    input  memTypes::lineIdxT     refillIdx,
    input  memTypes::wordOffT     refillWord,
    input  memTypes::tagT         refillTag,
    input  memTypes::memDataT     refillData
);

    logic [`ICACHE_LINES-1:0] lineValid;
    memTypes::tagT tagArray [`ICACHE_LINES];
    memTypes::memDataT dataArray [`ICACHE_LINES][`LINE_WORDS];
    memTypes::lineIdxT readIdx;
    memTypes::wordOffT groupWord;

    assign readIdx = memTypes::lineIdxOf(readPc);
    assign hit = lineValid[readIdx] && (tagArray[readIdx] == memTypes::tagOf(readPc));

    // First word of the group inside the line
    assign groupWord = memTypes::wordOf(readPc) & ~memTypes::wordOffT'(`FETCH_WIDTH - 1);

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            readWords[i] = dataArray[readIdx][groupWord + memTypes::wordOffT'(i)];
        end
    end

    // Line stays invalid until its last word lands
    always_ff @(posedge clk) begin
        if (rst) begin
            lineValid <= '0;
        end else if (refillWe) begin
            if (refillWord == memTypes::wordOffT'(`LINE_WORDS - 1)) begin
                lineValid[refillIdx] <= 1'b1;
            end else begin
                lineValid[refillIdx] <= 1'b0;
            end
        end
    end

    // Tag and data written with each response word
    always_ff @(posedge clk) begin
        if (refillWe) begin
            tagArray[refillIdx] <= refillTag;
            dataArray[refillIdx][refillWord] <= refillData;
        end
    end

endmodule

// File: design/refillTimer.sv
/*
 * Refill word timer
 * Counts accepted requests and responses for one cache line
 */
`include "fetch_macros.svh"

module refillTimer (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              reqFire,
    input  logic              respFire,
    output logic              reqDone,
    output logic              lastResp,
    output memTypes::wordOffT wordIdx
);

    memTypes::wordOffT reqCnt;

    // Both counters restart with each new line
    always_ff @(posedge clk) begin
        if (rst || start) begin
            reqCnt <= '0;
            wordIdx <= '0;
        end else begin
            if (reqFire) begin
                reqCnt <= reqCnt + 1'b1;
            end
            if (respFire) begin
                wordIdx <= wordIdx + 1'b1;
            end
        end
    end

    // High while the final request is accepted
    assign reqDone = reqFire && (reqCnt == memTypes::wordOffT'(`LINE_WORDS - 1));
    // High while the final response arrives
    assign lastResp = respFire && (wordIdx == memTypes::wordOffT'(`LINE_WORDS - 1));

endmodule

// File: design/missController.sv
/*
 * Cache miss controller
 * FSM that stalls fetch, requests a line and writes it into the cache
 */
`include "fetch_macros.svh"

module missController (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 miss,
    input  fetchTypes::pcT       missPc,
    output logic                 stall,
    output logic                 memReqValid,
    output memTypes::memAddrT    memReqAddr,
    input  logic                 memReqReady,
    input  logic                 memRespValid,
    input  memTypes::memDataT    memRespData,
    output memTypes::refillReqT  refill
);

    memTypes::refillStateT state;
    memTypes::refillStateT nextState;
    memTypes::memAddrT lineAddr;
    memTypes::wordOffT wordIdx;
    logic start;
    logic reqFire;
    logic respFire;
    logic reqDone;
    logic lastResp;

    assign start = (state == memTypes::IDLE) && miss;
    assign reqFire = memReqValid && memReqReady;
    // Responses only belong to a running refill
    assign respFire = memRespValid && (state != memTypes::IDLE);

    refillTimer u_refillTimer (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .reqFire  (reqFire),
        .respFire (respFire),
        .reqDone  (reqDone),
        .lastResp (lastResp),
        .wordIdx  (wordIdx)
    );

    always_comb begin
        nextState = state;
        case (state)
            memTypes::IDLE:      if (miss) nextState = memTypes::REQUEST;
            memTypes::REQUEST:   if (reqDone) nextState = memTypes::WAIT_LAST;
            memTypes::WAIT_LAST: if (lastResp) nextState = memTypes::IDLE;
            default:             nextState = memTypes::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memTypes::IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Line base latched on the miss, request address walks the line
    always_ff @(posedge clk) begin
        if (start) begin
            lineAddr <= memTypes::lineBase(missPc);
            memReqAddr <= memTypes::lineBase(missPc);
        end else if (reqFire) begin
            memReqAddr <= memReqAddr + memTypes::memAddrT'(`INSN_BYTES);
        end
    end

    // Fetch held from the miss cycle until back in IDLE
    assign stall = start || (state != memTypes::IDLE);
    assign memReqValid = (state == memTypes::REQUEST);

    // Each response word goes straight to the cache
    assign refill.we = respFire;
    assign refill.idx = memTypes::lineIdxOf(lineAddr);
    assign refill.word = wordIdx;
    assign refill.tag = memTypes::tagOf(lineAddr);
    assign refill.data = memRespData;

endmodule

// File: design/fetchStage.sv
/*
 * Fetch stage
 * Builds the group from cache words and BTB predictions,
 * kills lanes after a taken branch and holds the output for decode
 */
`include "fetch_macros.svh"

module fetchStage (
    input  logic                   clk,
    input  logic                   rst,
    input  fetchTypes::pcT         fetchPc,
    input  fetchTypes::redirectT   redirect,
    input  logic                   stall,
    input  logic                   hit,
    input  fetchTypes::insnGroupT  readWords,
    input  fetchTypes::predGroupT  pred,
    output fetchTypes::pcT         groupPc,
    output logic                   miss,
    output logic                   advance,
    output fetchTypes::pcT         predPc,
    output fetchTypes::fetchGroupT fetchOut,
    output logic                   outValid,
    input  logic                   outReady
);

    logic stageValid;
    logic load;
    logic takenSeen;
    logic [$clog2(`FETCH_WIDTH)-1:0] startLane;
    fetchTypes::fetchGroupT group;

    // Aligned group address and first lane addressed by the PC
    assign groupPc = fetchPc & ~fetchTypes::pcT'(`GROUP_BYTES - 1);
    assign startLane = fetchPc[$clog2(`INSN_BYTES) +: $clog2(`FETCH_WIDTH)];

    assign miss = stageValid && !hit;
    // Output slot free or draining this cycle
    assign load = stageValid && hit && !stall && !redirect.valid
                  && (!outValid || outReady);
    assign advance = load;

    always_comb begin
        takenSeen = 1'b0;
        predPc = groupPc + fetchTypes::pcT'(`GROUP_BYTES);
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            // Lanes before the start PC or after a taken lane are dead
            group[i].valid = (i >= int'(startLane)) && !takenSeen;
            group[i].pc = groupPc + fetchTypes::pcT'(i * `INSN_BYTES);
            group[i].insn = readWords[i];
            group[i].pred.predTaken = group[i].valid && pred[i].predTaken;
            group[i].pred.predTarget = pred[i].predTarget;
            if (group[i].pred.predTaken) begin
                // First taken lane steers the next fetch
                takenSeen = 1'b1;
                predPc = pred[i].predTarget;
            end
        end
    end

    // Fetch address is live except right after reset or a flush
    always_ff @(posedge clk) begin
        if (rst || redirect.valid) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect.valid) begin
            outValid <= 1'b0;
        end else if (load) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    // Held unchanged under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            fetchOut <= group;
        end
    end

endmodule

// File: design/fetchFrontEnd.sv
/*
 * Two-wide fetch front end
 * Next PC, fetch stage, instruction cache, BTB and miss refill
 */
module fetchFrontEnd (
    input  logic                   clk,
    input  logic                   rst,
    input  fetchTypes::redirectT   redirect,
    input  fetchTypes::btbUpdateT  btbUpdate,
    output fetchTypes::fetchGroupT fetchOut,
    output logic                   outValid,
    input  logic                   outReady,
    output logic                   memReqValid,
    output memTypes::memAddrT      memReqAddr,
    input  logic                   memReqReady,
    input  logic                   memRespValid,
    input  memTypes::memDataT      memRespData
);

    fetchTypes::pcT fetchPc;
    fetchTypes::pcT predPc;
    fetchTypes::pcT groupPc;
    fetchTypes::insnGroupT readWords;
    fetchTypes::predGroupT pred;
    memTypes::refillReqT refill;
    logic advance;
    logic hit;
    logic miss;
    logic stall;

    nextPcStage u_nextPcStage (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .advance  (advance),
        .predPc   (predPc),
        .fetchPc  (fetchPc)
    );

    fetchStage u_fetchStage (
        .clk       (clk),
        .rst       (rst),
        .fetchPc   (fetchPc),
        .redirect  (redirect),
        .stall     (stall),
        .hit       (hit),
        .readWords (readWords),
        .pred      (pred),
        .groupPc   (groupPc),
        .miss      (miss),
        .advance   (advance),
        .predPc    (predPc),
        .fetchOut  (fetchOut),
        .outValid  (outValid),
        .outReady  (outReady)
    );

    instCache u_instCache (
        .clk        (clk),
        .rst        (rst),
        .readPc     (groupPc),
        .hit        (hit),
        .readWords  (readWords),
        .refillWe   (refill.we),
        .refillIdx  (refill.idx),
        .refillWord (refill.word),
        .refillTag  (refill.tag),
        .refillData (refill.data)
    );

    branchTargetBuffer u_branchTargetBuffer (
        .clk       (clk),
        .rst       (rst),
        .btbUpdate (btbUpdate),
        .lookupPc  (groupPc),
        .pred      (pred)
    );

    // Miss address is the group being fetched
    missController u_missController (
        .clk          (clk),
        .rst          (rst),
        .miss         (miss),
        .missPc       (groupPc),
        .stall        (stall),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memReqReady  (memReqReady),
        .memRespValid (memRespValid),
        .memRespData  (memRespData),
        .refill       (refill)
    );

endmodule

// File: verif/fetchFrontEnd_checker.sv
/*
 * Bound protocol checks for the fetch front end
 * Decode handshake, refill requests and lane kill
 */
module fetchFrontEnd_checker (
    input logic                   clk,
    input logic                   rst,
    input fetchTypes::redirectT   redirect,
    input fetchTypes::fetchGroupT fetchOut,
    input logic                   outValid,
    input logic                   outReady,
    input logic                   memReqValid,
    input memTypes::memAddrT      memReqAddr,
    input memTypes::refillStateT  reqState,
    input memTypes::memAddrT      reqLine
);

    // Refused group stays valid and unchanged
    // Only a flush may drop it
    holdUnderBackPressure: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady && !redirect.valid |=> outValid && $stable(fetchOut))
        else $error("fetchOut changed or dropped while decode was not ready");

    // Memory reads only come from REQUEST and stay inside the line being refilled
    reqOnlyInRequest: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> reqState == memTypes::REQUEST
                        && memTypes::lineBase(memReqAddr) == reqLine)
        else $error("memory request issued outside the REQUEST state of its line");

    // Nothing survives behind a taken lane 0
    laneKillAfterTaken: assert property (@(posedge clk) disable iff (rst)
        outValid |-> !(fetchOut[0].valid && fetchOut[0].pred.predTaken && fetchOut[1].valid))
        else $error("lane 1 valid after a taken lane 0");

endmodule

// Attached to the front end with the miss FSM state and latched line address
bind fetchFrontEnd fetchFrontEnd_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .fetchOut    (fetchOut),
    .outValid    (outValid),
    .outReady    (outReady),
    .memReqValid (memReqValid),
    .memReqAddr  (memReqAddr),
    .reqState    (u_missController.state),
    .reqLine     (u_missController.lineAddr)
);

// File: verif/fetchFrontEnd_tb.sv
/*
 * Testbench for the two-wide fetch front end
 * Memory model with random latency, stimulus table, reference model and checks
 */
`include "fetch_macros.svh"

module fetchFrontEnd_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_GROUP = 64;
    // Memory word is its address scrambled by a fixed key
    localparam logic [31:0] MEM_KEY = 32'h5A3C_96E1;

    // One stimulus row
    typedef struct packed {
        fetchTypes::pcT startPc;
        logic           hasEntry;
        fetchTypes::pcT branchPc;
        fetchTypes::pcT target;
        logic [7:0]     groups;
        logic [7:0]     bpPct;
    } stimRowT;

    logic clk = 1'b0;
    logic rst;
    fetchTypes::redirectT redirect;
    fetchTypes::btbUpdateT btbUpdate;
    fetchTypes::fetchGroupT fetchOut;
    logic outValid;
    logic outReady;
    logic memReqValid;
    memTypes::memAddrT memReqAddr;
    logic memReqReady;
    logic memRespValid;
    memTypes::memDataT memRespData;

    integer seed = 83065;
    int errCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cyc = 0;
    int lastDue = 0;
    logic tableLoaded = 1'b0;
    logic [7:0] curBp;
    logic holdPending;
    fetchTypes::fetchGroupT heldGroup;

    stimRowT rows [$];
    // Groups taken by decode since the last redirect
    fetchTypes::fetchGroupT captured [$];
    // Outstanding memory reads, oldest first
    int respDue [$];
    memTypes::memAddrT respAddr [$];

    // Reference copy of the installed branch entries
    logic btbValid [`BTB_ENTRIES];
    fetchTypes::pcT btbPc [`BTB_ENTRIES];
    fetchTypes::pcT btbTarget [`BTB_ENTRIES];

    fetchFrontEnd u_dut (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .btbUpdate    (btbUpdate),
        .fetchOut     (fetchOut),
        .outValid     (outValid),
        .outReady     (outReady),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memReqReady  (memReqReady),
        .memRespValid (memRespValid),
        .memRespData  (memRespData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic memTypes::memDataT memWord(memTypes::memAddrT addr);
        return addr ^ MEM_KEY;
    endfunction

    // BTB slot from the word address bits
    function automatic int btbSlot(fetchTypes::pcT pc);
        return int'((pc / `INSN_BYTES) % `BTB_ENTRIES);
    endfunction

    task automatic addRow(input fetchTypes::pcT startPc, input logic hasEntry,
                          input fetchTypes::pcT branchPc, input fetchTypes::pcT target,
                          input int groups, input int bpPct);
        stimRowT row;
        row.startPc = startPc;
        row.hasEntry = hasEntry;
        row.branchPc = branchPc;
        row.target = target;
        row.groups = 8'(groups);
        row.bpPct = 8'(bpPct);
        rows.push_back(row);
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s expected %h got %h", what, exp, got);
            errCount++;
        end
    endtask

    // Group at the aligned PC, lanes live from the start offset up to the first taken one
    task automatic expectedGroup(input fetchTypes::pcT pc, output fetchTypes::fetchGroupT grp,
                                 output fetchTypes::pcT nextPc);
        fetchTypes::pcT aligned;
        fetchTypes::pcT lanePc;
        int startLane;
        int slot;
        logic taken;
        aligned = pc & ~fetchTypes::pcT'(`GROUP_BYTES - 1);
        startLane = int'((pc / `INSN_BYTES) % `FETCH_WIDTH);
        nextPc = aligned + fetchTypes::pcT'(`GROUP_BYTES);
        taken = 1'b0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lanePc = aligned + fetchTypes::pcT'(i * `INSN_BYTES);
            slot = btbSlot(lanePc);
            grp[i].valid = (i >= startLane) && !taken;
            grp[i].pc = lanePc;
            grp[i].insn = memWord(lanePc);
            grp[i].pred.predTaken = grp[i].valid && btbValid[slot] && (btbPc[slot] == lanePc);
            grp[i].pred.predTarget = btbTarget[slot];
            if (grp[i].pred.predTaken) begin
                // Later lanes die, next group comes from the target
                taken = 1'b1;
                nextPc = btbTarget[slot];
            end
        end
    endtask

    task automatic compareGroup(input int row, input int g, input fetchTypes::fetchGroupT got,
                                input fetchTypes::fetchGroupT exp);
        string where;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            where = $sformatf("row %0d group %0d fetchOut[%0d]", row, g, i);
            checkValue({where, ".valid"}, 32'(got[i].valid), 32'(exp[i].valid));
            checkValue({where, ".pc"}, got[i].pc, exp[i].pc);
            if (exp[i].valid) begin
                checkValue({where, ".insn"}, got[i].insn, exp[i].insn);
                checkValue({where, ".predTaken"}, 32'(got[i].pred.predTaken),
                           32'(exp[i].pred.predTaken));
            end
            // Target only means something on a taken lane
            if (exp[i].pred.predTaken) begin
                checkValue({where, ".predTarget"}, got[i].pred.predTarget,
                           exp[i].pred.predTarget);
            end
        end
    endtask

    // All falling-edge activity of one cycle
    task automatic runCycle(input logic flushing);
        int unsigned rnd;
        int due;
        cyc++;
        // Oldest response whose latency has run out
        if (respDue.size() > 0 && respDue[0] <= cyc) begin
            memRespValid = 1'b1;
            memRespData = memWord(respAddr.pop_front());
            due = respDue.pop_front();
        end else begin
            memRespValid = 1'b0;
            memRespData = '0;
        end
        rnd = $unsigned($random(seed));
        memReqReady = rnd[0];
        // Request fires at the coming rising edge
        if (memReqValid && memReqReady) begin
            rnd = $unsigned($random(seed));
            due = cyc + 1 + int'(rnd % 3);
            // In order, at most one response per cycle
            if (due <= lastDue) begin
                due = lastDue + 1;
            end
            lastDue = due;
            respDue.push_back(due);
            respAddr.push_back(memReqAddr);
        end
        // Group refused last cycle must still be there unchanged
        if (holdPending) begin
            assert (outValid === 1'b1 && fetchOut === heldGroup) else begin
                $display("Error: fetchOut expected %h got %h, outValid %h",
                         heldGroup, fetchOut, outValid);
                errCount++;
            end
        end
        rnd = $unsigned($random(seed));
        if (flushing) begin
            outReady = 1'b0;
        end else begin
            outReady = (rnd % 100) >= 32'(curBp);
        end
        if (flushing) begin
            holdPending = 1'b0;
        end else if (outValid && outReady) begin
            captured.push_back(fetchOut);
            holdPending = 1'b0;
        end else begin
            holdPending = outValid;
            heldGroup = fetchOut;
        end
    endtask

    initial begin : mainFlow
        fetchTypes::pcT pc;
        fetchTypes::fetchGroupT expGroup;
        int errBefore;
        int slot;
        rst = 1'b1;
        redirect = '0;
        btbUpdate = '0;
        outReady = 1'b0;
        memReqReady = 1'b0;
        memRespValid = 1'b0;
        memRespData = '0;
        curBp = '0;
        holdPending = 1'b0;
        heldGroup = '0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            btbValid[i] = 1'b0;
            btbPc[i] = '0;
            btbTarget[i] = '0;
        end

        // Start PC, BTB entry, groups to collect, back-pressure percent
        addRow(32'h0000_0000, 1'b0, 32'h0000_0000, 32'h0000_0000, 8, 0);
        addRow(32'h0000_0104, 1'b0, 32'h0000_0000, 32'h0000_0000, 3, 0);
        addRow(32'h0000_0040, 1'b1, 32'h0000_0040, 32'h0000_0200, 4, 0);
        addRow(32'h0000_0010, 1'b0, 32'h0000_0000, 32'h0000_0000, 10, 60);
        addRow(32'h0000_0084, 1'b1, 32'h0000_008C, 32'h0000_0024, 6, 40);
        // Target lands on an odd word next to the invalid lane of the 0x40 entry
        addRow(32'h0000_0300, 1'b1, 32'h0000_0308, 32'h0000_0044, 6, 80);
        addRow(32'h0000_1000, 1'b0, 32'h0000_0000, 32'h0000_0000, 5, 25);
        tableLoaded = 1'b1;

        // Front end stays quiet through reset
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkValue("outValid", 32'(outValid), 32'h0);
            checkValue("memReqValid", 32'(memReqValid), 32'h0);
        end
        rst = 1'b0;
        testsRun++;
        if (errCount > 0) begin
            testsFailed++;
        end
        $display("Test reset: %0d errors", errCount);

        for (int r = 0; r < rows.size(); r++) begin
            errBefore = errCount;
            curBp = rows[r].bpPct;
            @(negedge clk);
            if (rows[r].hasEntry) begin
                btbUpdate.valid = 1'b1;
                btbUpdate.branchPc = rows[r].branchPc;
                btbUpdate.target = rows[r].target;
                slot = btbSlot(rows[r].branchPc);
                btbValid[slot] = 1'b1;
                btbPc[slot] = rows[r].branchPc;
                btbTarget[slot] = rows[r].target;
            end
            runCycle(1'b0);
            // Flush in the middle of the running stream
            @(negedge clk);
            btbUpdate = '0;
            redirect.valid = 1'b1;
            redirect.pc = rows[r].startPc;
            runCycle(1'b1);
            captured.delete();
            @(negedge clk);
            redirect = '0;
            runCycle(1'b0);
            while (captured.size() < int'(rows[r].groups)) begin
                @(negedge clk);
                runCycle(1'b0);
            end
            // Walk the expected stream from the redirect PC
            pc = rows[r].startPc;
            for (int g = 0; g < int'(rows[r].groups); g++) begin
                expectedGroup(pc, expGroup, pc);
                compareGroup(r, g, captured[g], expGroup);
            end
            testsRun++;
            if (errCount > errBefore) begin
                testsFailed++;
            end
            $display("Test row %0d start %h: %0d groups, %0d errors",
                     r, rows[r].startPc, rows[r].groups, errCount - errBefore);
        end

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Budget grows with the number of groups in the table
    initial begin : watchdog
        int totalGroups;
        int limitCycles;
        totalGroups = 0;
        wait (tableLoaded);
        foreach (rows[i]) begin
            totalGroups += int'(rows[i].groups);
        end
        limitCycles = RESET_CYCLES + totalGroups * CYCLES_PER_GROUP;
        #(limitCycles * CLK_PERIOD);
        $display("Timeout: expected groups did not arrive within %0d cycles", limitCycles);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/fetchTypes.sv
design/memTypes.sv
design/nextPcStage.sv
design/branchTargetBuffer.sv
design/instCache.sv
design/refillTimer.sv
design/missController.sv
design/fetchStage.sv
design/fetchFrontEnd.sv
verif/fetchFrontEnd_checker.sv
verif/fetchFrontEnd_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch front end regression with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module fetchFrontEnd_tb
# Output goes to the terminal, the search decides the exit status
./obj_dir/VfetchFrontEnd_tb | tee /dev/stderr | grep -c "Regression passed" > /dev/null
